//--- Makefile
TOP := tb_router

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "TEST PASSED" > /dev/null

lint:
	verilator --lint-only -Wall --top-module router_top router_pkg.sv input_stage.sv \
		switch_alloc.sv output_stage.sv router_top.sv
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir

//--- input_stage.sv
`timescale 1ns/1ns
`default_nettype none

module input_stage #(
    parameter int QUEUE_DEPTH = 16
) (
    input  wire                                            clk,
    input  wire                                            rst,
    input  wire router_pkg::flit_t [router_pkg::PORT_NUM-1:0] in_flit,
    input  wire  [router_pkg::PORT_NUM-1:0]                in_valid,
    input  wire  [router_pkg::PORT_NUM-1:0]                pop,
    output router_pkg::flit_t      [router_pkg::PORT_NUM-1:0] head_flit,
    output logic [router_pkg::PORT_NUM-1:0]                head_valid,
    output logic [router_pkg::PORT_NUM-1:0]                credit_upd,
    output router_pkg::credit_t    [router_pkg::PORT_NUM-1:0] credit_val,
    output router_pkg::credit_t    [router_pkg::PORT_NUM-1:0] free_cnt
);
    import router_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // data flit offered to each queue, queue full
    logic [PORT_NUM-1:0] wr_req;
    logic [PORT_NUM-1:0] full;

    genvar p;
    generate
        for (p = 0; p < PORT_NUM; p++) begin : g_port
            flit_t            mem [QUEUE_DEPTH];
            logic [PTR_W-1:0] wr_ptr;
            logic [PTR_W-1:0] rd_ptr;
            logic [CNT_W-1:0] used;
            logic             is_credit;
            logic             push;
            logic             do_pop;

            assign is_credit = flit_kind(in_flit[p]) == KIND_CREDIT;
            assign wr_req[p] = in_valid[p] && !is_credit;
            assign full[p]   = used == CNT_W'(QUEUE_DEPTH);
            // a write into a full queue is lost
            assign push      = wr_req[p] && !full[p];
            assign do_pop    = pop[p] && head_valid[p];

            always_ff @(posedge clk) begin
                if (push) begin
                    mem[wr_ptr] <= in_flit[p];
                end
            end

            always_ff @(posedge clk) begin
                if (rst) begin
                    wr_ptr <= '0;
                    rd_ptr <= '0;
                    used   <= '0;
                end else begin
                    if (push) begin
                        wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                    end
                    if (do_pop) begin
                        rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                    end
                    case ({push, do_pop})
                        2'b10:   used <= used + 1'b1;
                        2'b01:   used <= used - 1'b1;
                        default: used <= used;
                    endcase
                end
            end

            // show-ahead head
            assign head_flit[p]  = mem[rd_ptr];
            assign head_valid[p] = used != '0;

            // credit flits bypass the queue
            assign credit_upd[p] = in_valid[p] && is_credit;
            assign credit_val[p] = credit_t'(in_flit[p][CREDIT_W-1:0]);

            // one slot kept back for a flit in flight
            assign free_cnt[p] = (int'(used) >= QUEUE_DEPTH - 1) ? '0 :
                                 credit_t'(QUEUE_DEPTH - 1 - int'(used));
        end
    endgenerate

endmodule

`default_nettype wire

//--- output_stage.sv
`timescale 1ns/1ns
`default_nettype none

module output_stage #(
    parameter int QUEUE_DEPTH      = 16,
    parameter int CREDIT_PERIOD    = 20,
    parameter int CREDIT_THRESHOLD = 4
) (
    input  wire                                              clk,
    input  wire                                              rst,
    input  wire  [router_pkg::PORT_NUM-1:0]                  credit_upd,
    input  wire router_pkg::credit_t [router_pkg::PORT_NUM-1:0] credit_val,
    input  wire router_pkg::credit_t [router_pkg::PORT_NUM-1:0] free_cnt,
    input  wire router_pkg::flit_t   [router_pkg::PORT_NUM-1:0] sw_flit,
    input  wire  [router_pkg::PORT_NUM-1:0]                  sw_valid,
    input  wire router_pkg::flit_t   [router_pkg::PORT_NUM-1:0] ej_flit,
    input  wire  [router_pkg::PORT_NUM-1:0]                  ej_valid,
    input  wire router_pkg::flit_t   [router_pkg::PORT_NUM-1:0] inject_flit,
    input  wire  [router_pkg::PORT_NUM-1:0]                  inject_valid,
    output logic [router_pkg::PORT_NUM-1:0]                  out_open,
    output logic [router_pkg::PORT_NUM-1:0]                  inject_avail,
    output router_pkg::flit_t        [router_pkg::PORT_NUM-1:0] out_flit,
    output logic [router_pkg::PORT_NUM-1:0]                  out_valid,
    output router_pkg::flit_t        [router_pkg::PORT_NUM-1:0] eject_flit,
    output logic [router_pkg::PORT_NUM-1:0]                  eject_valid
);
    import router_pkg::*;

    localparam int PER_W = $clog2(CREDIT_PERIOD + 1);

    logic [PER_W-1:0]    period_cnt;
    logic                credit_slot;
    credit_t             dn_credit [PORT_NUM];
    logic [PORT_NUM-1:0] credit_ok;
    logic [PORT_NUM-1:0] inj_own;

    // shared by all ports
    assign credit_slot = period_cnt == PER_W'(CREDIT_PERIOD - 1);

    always_ff @(posedge clk) begin
        if (rst || credit_slot) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    // last credit value heard from downstream, and packet ownership
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < PORT_NUM; p++) begin
                dn_credit[p] <= credit_t'(QUEUE_DEPTH - 1);
            end
            inj_own <= '0;
        end else begin
            for (int p = 0; p < PORT_NUM; p++) begin
                if (credit_upd[p]) begin
                    dn_credit[p] <= credit_val[p];
                end
                if (inject_valid[p] && !sw_valid[p] &&
                    flit_kind(inject_flit[p]) == KIND_HEAD) begin
                    inj_own[p] <= 1'b1;
                end else if (inject_valid[p] && flit_kind(inject_flit[p]) == KIND_TAIL) begin
                    inj_own[p] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < PORT_NUM; p++) begin
            credit_ok[p]    = int'(dn_credit[p]) >= CREDIT_THRESHOLD;
            out_open[p]     = credit_ok[p] && !credit_slot && !inj_own[p];
            inject_avail[p] = credit_ok[p] && !credit_slot && (inj_own[p] || !sw_valid[p]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid   <= '0;
            eject_valid <= '0;
        end else begin
            out_valid   <= {PORT_NUM{credit_slot}} | sw_valid | inject_valid;
            eject_valid <= ej_valid;
        end
    end

    // credit flit first, then through traffic, then injection
    always_ff @(posedge clk) begin
        for (int p = 0; p < PORT_NUM; p++) begin
            if (credit_slot) begin
                out_flit[p] <= credit_flit(free_cnt[p]);
            end else if (sw_valid[p]) begin
                out_flit[p] <= sw_flit[p];
            end else begin
                out_flit[p] <= inject_flit[p];
            end
        end
        eject_flit <= ej_flit;
    end

endmodule

`default_nettype wire

//--- router_pkg.sv
`default_nettype none

package router_pkg;

    localparam int FLIT_W    = 32;
    localparam int COORD_W   = 4;
    localparam int CREDIT_W  = 8;
    localparam int PORT_NUM  = 4;
    localparam int KIND_W    = 2;
    localparam int PAYLOAD_W = 16;

    // field offsets, kind in the top bits
    localparam int KIND_LSB   = FLIT_W - KIND_W;
    localparam int DEST_X_LSB = KIND_LSB - COORD_W;
    localparam int DEST_Y_LSB = DEST_X_LSB - COORD_W;

    typedef logic [FLIT_W-1:0]   flit_t;
    typedef logic [COORD_W-1:0]  coord_t;
    typedef logic [CREDIT_W-1:0] credit_t;

    typedef enum logic [KIND_W-1:0] {
        KIND_HEAD   = 2'd0,
        KIND_BODY   = 2'd1,
        KIND_TAIL   = 2'd2,
        KIND_CREDIT = 2'd3
    } flit_kind_t;

    typedef enum logic [1:0] {
        PORT_XPOS = 2'd0,
        PORT_YPOS = 2'd1,
        PORT_XNEG = 2'd2,
        PORT_YNEG = 2'd3
    } port_t;

    function automatic flit_kind_t flit_kind(input flit_t f);
        return flit_kind_t'(f[FLIT_W-1 -: KIND_W]);
    endfunction

    function automatic coord_t flit_dest_x(input flit_t f);
        return f[DEST_X_LSB +: COORD_W];
    endfunction

    function automatic coord_t flit_dest_y(input flit_t f);
        return f[DEST_Y_LSB +: COORD_W];
    endfunction

    // credit value rides in the payload, dest fields zero
    function automatic flit_t credit_flit(input credit_t c);
        flit_t f;
        f = '0;
        f[FLIT_W-1 -: KIND_W] = KIND_CREDIT;
        f[PAYLOAD_W-1:0] = PAYLOAD_W'(c);
        return f;
    endfunction

endpackage

`default_nettype wire

//--- router_top.sv
`timescale 1ns/1ns
`default_nettype none

module router_top #(
    parameter router_pkg::coord_t cur_x = '0,
    parameter router_pkg::coord_t cur_y = '0,
    parameter int QUEUE_DEPTH      = 16,
    parameter int CREDIT_PERIOD    = 20,
    parameter int CREDIT_THRESHOLD = 4
) (
    input  wire                                            clk,
    input  wire                                            rst,
    // network side
    input  wire router_pkg::flit_t [router_pkg::PORT_NUM-1:0] in_flit,
    input  wire  [router_pkg::PORT_NUM-1:0]                in_valid,
    output router_pkg::flit_t      [router_pkg::PORT_NUM-1:0] out_flit,
    output logic [router_pkg::PORT_NUM-1:0]                out_valid,
    // local kernel side
    input  wire router_pkg::flit_t [router_pkg::PORT_NUM-1:0] inject_flit,
    input  wire  [router_pkg::PORT_NUM-1:0]                inject_valid,
    output logic [router_pkg::PORT_NUM-1:0]                inject_avail,
    output router_pkg::flit_t      [router_pkg::PORT_NUM-1:0] eject_flit,
    output logic [router_pkg::PORT_NUM-1:0]                eject_valid
);
    import router_pkg::*;

    flit_t   [PORT_NUM-1:0] head_flit;
    logic    [PORT_NUM-1:0] head_valid;
    logic    [PORT_NUM-1:0] pop;
    logic    [PORT_NUM-1:0] credit_upd;
    credit_t [PORT_NUM-1:0] credit_val;
    credit_t [PORT_NUM-1:0] free_cnt;
    logic    [PORT_NUM-1:0] out_open;
    flit_t   [PORT_NUM-1:0] sw_flit;
    logic    [PORT_NUM-1:0] sw_valid;
    flit_t   [PORT_NUM-1:0] ej_flit;
    logic    [PORT_NUM-1:0] ej_valid;

    input_stage #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_input_stage (
        .clk        (clk),
        .rst        (rst),
        .in_flit    (in_flit),
        .in_valid   (in_valid),
        .pop        (pop),
        .head_flit  (head_flit),
        .head_valid (head_valid),
        .credit_upd (credit_upd),
        .credit_val (credit_val),
        .free_cnt   (free_cnt)
    );

    switch_alloc #(
        .cur_x(cur_x),
        .cur_y(cur_y)
    ) u_switch_alloc (
        .clk        (clk),
        .rst        (rst),
        .head_flit  (head_flit),
        .head_valid (head_valid),
        .out_open   (out_open),
        .pop        (pop),
        .sw_flit    (sw_flit),
        .sw_valid   (sw_valid),
        .ej_flit    (ej_flit),
        .ej_valid   (ej_valid)
    );

    output_stage #(
        .QUEUE_DEPTH      (QUEUE_DEPTH),
        .CREDIT_PERIOD    (CREDIT_PERIOD),
        .CREDIT_THRESHOLD (CREDIT_THRESHOLD)
    ) u_output_stage (
        .clk          (clk),
        .rst          (rst),
        .credit_upd   (credit_upd),
        .credit_val   (credit_val),
        .free_cnt     (free_cnt),
        .sw_flit      (sw_flit),
        .sw_valid     (sw_valid),
        .ej_flit      (ej_flit),
        .ej_valid     (ej_valid),
        .inject_flit  (inject_flit),
        .inject_valid (inject_valid),
        .out_open     (out_open),
        .inject_avail (inject_avail),
        .out_flit     (out_flit),
        .out_valid    (out_valid),
        .eject_flit   (eject_flit),
        .eject_valid  (eject_valid)
    );

endmodule

`default_nettype wire

//--- switch_alloc.sv
`timescale 1ns/1ns
`default_nettype none

module switch_alloc #(
    parameter router_pkg::coord_t cur_x = '0,
    parameter router_pkg::coord_t cur_y = '0
) (
    input  wire                                            clk,
    input  wire                                            rst,
    input  wire router_pkg::flit_t [router_pkg::PORT_NUM-1:0] head_flit,
    input  wire  [router_pkg::PORT_NUM-1:0]                head_valid,
    input  wire  [router_pkg::PORT_NUM-1:0]                out_open,
    output logic [router_pkg::PORT_NUM-1:0]                pop,
    output router_pkg::flit_t      [router_pkg::PORT_NUM-1:0] sw_flit,
    output logic [router_pkg::PORT_NUM-1:0]                sw_valid,
    output router_pkg::flit_t      [router_pkg::PORT_NUM-1:0] ej_flit,
    output logic [router_pkg::PORT_NUM-1:0]                ej_valid
);
    import router_pkg::*;

    port_t               route [PORT_NUM];
    logic [PORT_NUM-1:0] local_hit;
    port_t               rr_ptr [PORT_NUM];
    port_t               winner [PORT_NUM];
    logic [PORT_NUM-1:0] grant_any;
    logic [PORT_NUM-1:0] granted_in;

    // dimension order, x before y
    always_comb begin
        for (int i = 0; i < PORT_NUM; i++) begin
            local_hit[i] = 1'b0;
            if (flit_dest_x(head_flit[i]) > cur_x) begin
                route[i] = PORT_XPOS;
            end else if (flit_dest_x(head_flit[i]) < cur_x) begin
                route[i] = PORT_XNEG;
            end else if (flit_dest_y(head_flit[i]) > cur_y) begin
                route[i] = PORT_YPOS;
            end else if (flit_dest_y(head_flit[i]) < cur_y) begin
                route[i] = PORT_YNEG;
            end else begin
                route[i]     = PORT_XPOS;
                local_hit[i] = 1'b1;
            end
        end
    end

    // round-robin per output, search starts at rr_ptr
    always_comb begin
        int idx;
        granted_in = '0;
        for (int o = 0; o < PORT_NUM; o++) begin
            grant_any[o] = 1'b0;
            winner[o]    = rr_ptr[o];
            for (int k = 0; k < PORT_NUM; k++) begin
                idx = (int'(rr_ptr[o]) + k) % PORT_NUM;
                if (!grant_any[o] && out_open[o] && head_valid[idx] &&
                    !local_hit[idx] && route[idx] == port_t'(o)) begin
                    grant_any[o] = 1'b1;
                    winner[o]    = port_t'(idx);
                end
            end
            if (grant_any[o]) begin
                granted_in[winner[o]] = 1'b1;
            end
        end
    end

    // crossbar and eject
    always_comb begin
        for (int o = 0; o < PORT_NUM; o++) begin
            sw_valid[o] = grant_any[o];
            sw_flit[o]  = head_flit[winner[o]];
        end
        for (int i = 0; i < PORT_NUM; i++) begin
            ej_valid[i] = head_valid[i] && local_hit[i];
            ej_flit[i]  = head_flit[i];
            pop[i]      = granted_in[i] || ej_valid[i];
        end
    end

    // pointer moves one past the winner
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int o = 0; o < PORT_NUM; o++) begin
                rr_ptr[o] <= PORT_XPOS;
            end
        end else begin
            for (int o = 0; o < PORT_NUM; o++) begin
                if (grant_any[o]) begin
                    rr_ptr[o] <= port_t'((int'(winner[o]) + 1) % PORT_NUM);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_router.sv
`timescale 1ns/1ns
`default_nettype none

module tb_router;
    import router_pkg::*;

    localparam coord_t CUR_X            = 4'd5;
    localparam coord_t CUR_Y            = 4'd5;
    localparam int     QUEUE_DEPTH      = 16;
    localparam int     CREDIT_PERIOD    = 20;
    localparam int     CREDIT_THRESHOLD = 4;
    localparam int     N_RAND           = 300;
    localparam int     INJ_SRC          = 4;
    // reset, idle periods, random traffic, back-pressure hold, four packets
    localparam int     STIM_CYCLES = 10 + 5 * CREDIT_PERIOD + N_RAND + 60 + 4 * 30;
    localparam int     CYCLE_LIMIT = 2 * STIM_CYCLES + 200;

    logic                 clk;
    logic                 rst;
    flit_t [PORT_NUM-1:0] in_flit;
    logic  [PORT_NUM-1:0] in_valid;
    flit_t [PORT_NUM-1:0] out_flit;
    logic  [PORT_NUM-1:0] out_valid;
    flit_t [PORT_NUM-1:0] inject_flit;
    logic  [PORT_NUM-1:0] inject_valid;
    logic  [PORT_NUM-1:0] inject_avail;
    flit_t [PORT_NUM-1:0] eject_flit;
    logic  [PORT_NUM-1:0] eject_valid;

    // out port * 5 + source, then one queue per eject
    flit_t exp_q [PORT_NUM * 6][$];
    int    outstanding [PORT_NUM];
    int    data_seen [PORT_NUM];
    int    last_credit [PORT_NUM];
    int    seq;
    int    errors;
    int    checks;
    int    flits_seen;
    int    slot_cnt;
    int    own_port;
    int    cycle = 0;
    logic  idle_check;

    router_top #(
        .cur_x            (CUR_X),
        .cur_y            (CUR_Y),
        .QUEUE_DEPTH      (QUEUE_DEPTH),
        .CREDIT_PERIOD    (CREDIT_PERIOD),
        .CREDIT_THRESHOLD (CREDIT_THRESHOLD)
    ) u_router_top (
        .clk          (clk),
        .rst          (rst),
        .in_flit      (in_flit),
        .in_valid     (in_valid),
        .out_flit     (out_flit),
        .out_valid    (out_valid),
        .inject_flit  (inject_flit),
        .inject_valid (inject_valid),
        .inject_avail (inject_avail),
        .eject_flit   (eject_flit),
        .eject_valid  (eject_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, flits still expected %0d", cycle, pending_flits());
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    function automatic flit_t make_flit(input logic [1:0] kind, input coord_t dx,
                                        input coord_t dy, input int src, input int sq);
        return {kind, dx, dy, 6'b0, 3'(src), 13'(sq)};
    endfunction

    function automatic flit_t credit_word(input int val);
        return {2'b11, 14'b0, 16'(val)};
    endfunction

    // x first, then y; PORT_NUM means local delivery
    function automatic int route_of(input coord_t dx, input coord_t dy);
        if (dx > CUR_X) return int'(PORT_XPOS);
        if (dx < CUR_X) return int'(PORT_XNEG);
        if (dy > CUR_Y) return int'(PORT_YPOS);
        if (dy < CUR_Y) return int'(PORT_YNEG);
        return PORT_NUM;
    endfunction

    function automatic int pending_flits();
        int n = 0;
        for (int q = 0; q < PORT_NUM * 6; q++) begin
            n += exp_q[q].size();
        end
        return n;
    endfunction

    task automatic pick_dest(input int o, output coord_t dx, output coord_t dy);
        dx = CUR_X;
        dy = 4'($urandom_range(0, 15));
        case (o)
            0:       dx = 4'($urandom_range(int'(CUR_X) + 1, 15));
            2:       dx = 4'($urandom_range(0, int'(CUR_X) - 1));
            1:       dy = 4'($urandom_range(int'(CUR_Y) + 1, 15));
            default: dy = 4'($urandom_range(0, int'(CUR_Y) - 1));
        endcase
    endtask

    task automatic send_data(input int i, input coord_t dx, input coord_t dy);
        flit_t f;
        int    o;
        f = make_flit(2'($urandom_range(0, 2)), dx, dy, i, seq);
        seq++;
        o = route_of(dx, dy);
        in_flit[i]  = f;
        in_valid[i] = 1'b1;
        outstanding[i]++;
        exp_q[(o == PORT_NUM) ? PORT_NUM * 5 + i : o * 5 + i].push_back(f);
    endtask

    task automatic send_credit(input int i, input int val);
        in_flit[i]  = credit_word(val);
        in_valid[i] = 1'b1;
    endtask

    // next drive point, strobes cleared
    task automatic step();
        @(posedge clk);
        #1;
        in_valid     = '0;
        inject_valid = '0;
    endtask

    task automatic drain();
        while (pending_flits() != 0) begin
            step();
        end
        repeat (3) step();
    endtask

    task automatic match_flit(input int qi, input flit_t f, input string name);
        int src;
        src = int'(f[15:13]);
        if (exp_q[qi].size() == 0) begin
            errors++;
            $display("Error at %0t ns: %s carried %h, which was not expected there", $time, name, f);
        end else begin
            check_value(name, f, exp_q[qi].pop_front());
        end
        if (src < PORT_NUM) outstanding[src]--;
        flits_seen++;
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    // head, body, tail on one port, plus through traffic aimed at it
    task automatic send_packet(input int o);
        flit_t  pkt [3];
        int     k;
        int     cur;
        int     pend;
        coord_t dx;
        coord_t dy;
        pkt[0] = make_flit(KIND_HEAD, 4'd0, 4'd0, INJ_SRC, seq);
        pkt[1] = make_flit(KIND_BODY, 4'd0, 4'd0, INJ_SRC, seq + 1);
        pkt[2] = make_flit(KIND_TAIL, 4'd0, 4'd0, INJ_SRC, seq + 2);
        seq += 3;
        k = 0;
        pend = -1;
        while (k < 3 || pend >= 0) begin
            cur = -1;
            if (k < 3 && inject_avail[o]) begin
                inject_flit[o]  = pkt[k];
                inject_valid[o] = 1'b1;
                exp_q[o * 5 + INJ_SRC].push_back(pkt[k]);
                if (k == 0) begin
                    own_port = o;
                end else if (outstanding[(o + 1) % PORT_NUM] < QUEUE_DEPTH - 1) begin
                    pick_dest(o, dx, dy);
                    send_data((o + 1) % PORT_NUM, dx, dy);
                end
                cur = k;
                k++;
            end
            @(negedge clk);
            if (pend >= 0) begin
                check_value("out_valid", out_valid[o], 1'b1);
                check_value("out_flit", out_flit[o], pkt[pend]);
            end
            step();
            pend = cur;
        end
        own_port = -1;
    endtask

    always @(negedge clk) begin : monitor
        int src;
        if (!rst) begin
            for (int p = 0; p < PORT_NUM; p++) begin
                src = int'(out_flit[p][15:13]);
                if (out_valid[p] && out_flit[p][31:30] == 2'b11) begin
                    if (last_credit[p] >= 0) begin
                        check_value("credit period", cycle - last_credit[p], CREDIT_PERIOD);
                    end
                    last_credit[p] = cycle;
                    if (idle_check) begin
                        check_value("out_flit", out_flit[p], credit_word(QUEUE_DEPTH - 1));
                    end
                    if (p == 0) slot_cnt++;
                end else if (out_valid[p]) begin
                    data_seen[p]++;
                    if (own_port == p && src != INJ_SRC) begin
                        errors++;
                        $display("Error at %0t ns: through flit %h broke into the packet on port %0d",
                                 $time, out_flit[p], p);
                    end
                    match_flit(p * 5 + ((src > INJ_SRC) ? INJ_SRC : src), out_flit[p], "out_flit");
                end
                if (eject_valid[p]) begin
                    match_flit(PORT_NUM * 5 + p, eject_flit[p], "eject_flit");
                end
            end
        end
    end

    initial begin
        int     e;
        int     o;
        int     s;
        int     n;
        coord_t dx;
        coord_t dy;
        void'($urandom(32'he059_1671));
        rst = 1'b1;
        in_flit = '0;
        in_valid = '0;
        inject_flit = '0;
        inject_valid = '0;
        idle_check = 1'b0;
        own_port = -1;
        seq = 0;
        errors = 0;
        checks = 0;
        flits_seen = 0;
        slot_cnt = 0;
        for (int p = 0; p < PORT_NUM; p++) begin
            outstanding[p] = 0;
            data_seen[p] = 0;
            last_credit[p] = -1;
        end
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;

        e = errors;
        for (int k = 0; k < CREDIT_PERIOD - 1; k++) begin
            @(negedge clk);
            check_value("out_valid", out_valid, 4'h0);
            check_value("eject_valid", eject_valid, 4'h0);
            check_value("inject_avail", inject_avail, 4'hf);
        end
        @(negedge clk);
        check_value("inject_avail", inject_avail, 4'h0);
        @(negedge clk);
        check_value("out_valid", out_valid, 4'hf);
        report_test("reset state", e);
        step();

        e = errors;
        idle_check = 1'b1;
        s = slot_cnt;
        while (slot_cnt < s + 4) step();
        idle_check = 1'b0;
        report_test("credit flits", e);

        e = errors;
        for (int c = 0; c < N_RAND; c++) begin
            for (int i = 0; i < PORT_NUM; i++) begin
                if (outstanding[i] < QUEUE_DEPTH - 1 && $urandom_range(0, 1) == 1) begin
                    dx = 4'($urandom_range(3, 7));
                    dy = 4'($urandom_range(4, 6));
                    send_data(i, dx, dy);
                end
            end
            step();
        end
        drain();
        report_test("routing and ejection", e);

        e = errors;
        o = $urandom_range(0, PORT_NUM - 1);
        s = (o + 1) % PORT_NUM;
        send_credit(o, CREDIT_THRESHOLD - 1);
        step();
        n = data_seen[o];
        for (int k = 0; k < 36; k++) begin
            check_value("inject_avail", inject_avail[o], 1'b0);
            if (k < 6) begin
                pick_dest(o, dx, dy);
                send_data(s, dx, dy);
            end
            step();
        end
        check_value("through flits on out_flit", data_seen[o] - n, 0);
        send_credit(o, QUEUE_DEPTH - 1);
        step();
        drain();
        report_test("credit back-pressure", e);

        e = errors;
        for (int p = 0; p < PORT_NUM; p++) begin
            send_packet(p);
        end
        drain();
        report_test("injection packets", e);

        $display("tests 5, checks %0d, errors %0d, flits %0d", checks, errors, flits_seen);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_router_chk.sv
`timescale 1ns/1ns
`default_nettype none

module tb_router_chk (
    input wire                                               clk,
    input wire                                               rst,
    input wire [router_pkg::PORT_NUM-1:0]                    wr_req,
    input wire [router_pkg::PORT_NUM-1:0]                    full,
    input wire                                               credit_slot,
    input wire [router_pkg::PORT_NUM-1:0]                    out_valid,
    input wire [router_pkg::PORT_NUM-1:0]                    inject_avail,
    input wire router_pkg::flit_t [router_pkg::PORT_NUM-1:0] out_flit
);
    import router_pkg::*;

    logic [PORT_NUM-1:0] credit_out;

    always_comb begin
        for (int p = 0; p < PORT_NUM; p++) begin
            credit_out[p] = out_flit[p][FLIT_W-1 -: KIND_W] == KIND_CREDIT;
        end
    end

    a_no_full_write: assert property (@(posedge clk) disable iff (rst)
        (wr_req & full) == '0)
        else $error("input queue written while full");

    // every port sends its credit flit right after the slot
    a_credit_in_slot: assert property (@(posedge clk) disable iff (rst)
        credit_slot |=> (out_valid == '1 && credit_out == '1))
        else $error("credit flit missing after the credit slot");

    a_credit_only_slot: assert property (@(posedge clk) disable iff (rst)
        !credit_slot |=> (out_valid & credit_out) == '0)
        else $error("credit flit outside the credit slot");

    a_avail_low_in_slot: assert property (@(posedge clk) disable iff (rst)
        credit_slot |-> inject_avail == '0)
        else $error("inject_avail high in the credit slot");

endmodule

bind input_stage tb_router_chk u_in_chk (
    .clk          (clk),
    .rst          (rst),
    .wr_req       (wr_req),
    .full         (full),
    .credit_slot  (1'b0),
    .out_valid    ('0),
    .inject_avail ('0),
    .out_flit     ('0)
);

bind output_stage tb_router_chk u_out_chk (
    .clk          (clk),
    .rst          (rst),
    .wr_req       ('0),
    .full         ('0),
    .credit_slot  (credit_slot),
    .out_valid    (out_valid),
    .inject_avail (inject_avail),
    .out_flit     (out_flit)
);

`default_nettype wire

//--- vlog.f
router_pkg.sv
input_stage.sv
switch_alloc.sv
output_stage.sv
router_top.sv
tb_router_chk.sv
tb_router.sv
